// File: dv/exp_trace.txt
# one job per line: input double in hex.
# expected sums follow from the truncating series model in the testbench.
0000000000000000
3fe0000000000000
3ff0000000000000
4000000000000000
400e000000000000
bfe0000000000000
bff0000000000000
c004000000000000

// File: dv/fp_exp_sva.sv
module fp_exp_sva import fp_exp_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input seq_state_t state,
  input logic       done,
  input logic       last,
  input logic [3:0] unit_start, // add, mul, div, conv.
  input logic [3:0] unit_done
);

  timeunit 1ns;
  timeprecision 1ps;

  logic       pending [4];
  logic [6:0] wait_cnt [4];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        pending[i]  <= 1'b0;
        wait_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (unit_start[i]) begin
          pending[i]  <= 1'b1;
          wait_cnt[i] <= '0;
        end else if (unit_done[i]) begin
          pending[i] <= 1'b0;
        end else if (pending[i]) begin
          wait_cnt[i] <= wait_cnt[i] + 7'd1;
        end
      end
    end
  end

  one_start_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(unit_start))
    else $error("more than one unit started in the same cycle");

  // finish follows straight on the adder's done for the last term.
  done_state_a: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> state == finish && $past(unit_done[0] && last))
    else $error("done outside finish or before the last term was summed");

  for (genvar i = 0; i < 4; i++) begin : g_latency
    latency_a: assert property (@(posedge clk) disable iff (!rst_n)
      !(pending[i] && wait_cnt[i] >= 7'd60))
      else $error("unit %0d gave no done within 60 cycles", i);
  end

endmodule

bind exp_sequencer fp_exp_sva sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .state      (state),
  .done       (done),
  .last       (last),
  .unit_start ({conv_if.start, div_if.start, mul_if.start, add_if.start}),
  .unit_done  ({conv_if.done, div_if.done, mul_if.done, add_if.done})
);

// File: dv/fp_exp_tb.sv
module fp_exp_tb import fp_exp_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int terms = 7;
  localparam int done_timeout = 2000;

  logic clk;
  logic rst_n;
  fp_t  fp_in;
  logic start;
  fp_t  fp_out;
  logic done;

  int   errors;
  int   timeouts;
  fp_t  inputs[$];

  fp_exp_top #(.iterations(terms)) UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .fp_in  (fp_in),
    .start  (start),
    .fp_out (fp_out),
    .done   (done)
  );

  always #50 clk = ~clk;

  // truncating reference arithmetic.
  function automatic fp_t add_trunc(fp_t a, fp_t b);
    logic [10:0] ea, eb, el, diff;
    logic [52:0] ml, ms;
    logic [53:0] s;
    logic        sgn;
    int          e;
    ea = a[62:52];
    eb = b[62:52];
    if (a[62:0] >= b[62:0]) begin
      ml = (ea == 0) ? '0 : {1'b1, a[51:0]};
      ms = (eb == 0) ? '0 : {1'b1, b[51:0]};
      el = ea;
      diff = ea - eb;
      sgn = a[63];
    end else begin
      ml = (eb == 0) ? '0 : {1'b1, b[51:0]};
      ms = (ea == 0) ? '0 : {1'b1, a[51:0]};
      el = eb;
      diff = eb - ea;
      sgn = b[63];
    end
    ms = ms >> diff;
    s = (a[63] == b[63]) ? {1'b0, ml} + {1'b0, ms} : {1'b0, ml} - {1'b0, ms};
    if (s == '0) return '0;
    e = int'(el);
    if (s[53]) begin
      s = s >> 1;
      e = e + 1;
    end else begin
      while (!s[52]) begin
        s = s << 1;
        e = e - 1;
      end
    end
    if (e <= 0) return '0;
    return {sgn, e[10:0], s[51:0]};
  endfunction

  function automatic fp_t mul_trunc(fp_t a, fp_t b);
    logic [105:0] p;
    logic [51:0]  frac;
    int           e;
    if (a[62:52] == 0 || b[62:52] == 0) return '0;
    p = 106'({1'b1, a[51:0]}) * 106'({1'b1, b[51:0]});
    e = int'(a[62:52]) + int'(b[62:52]) - 1023;
    if (p[105]) begin
      frac = p[104:53];
      e = e + 1;
    end else begin
      frac = p[103:52];
    end
    if (e <= 0) return '0;
    return {a[63] ^ b[63], e[10:0], frac};
  endfunction

  function automatic fp_t div_trunc(fp_t a, fp_t b);
    logic [53:0]  r;
    logic [52:0]  mb;
    logic [105:0] q;
    int           e;
    if (a[62:52] == 0) return '0;
    r = {1'b0, 1'b1, a[51:0]};
    mb = {1'b1, b[51:0]};
    e = int'(a[62:52]) - int'(b[62:52]) + 1023;
    if (r < {1'b0, mb}) begin
      r = r << 1;
      e = e - 1;
    end
    q = {r, 52'd0} / 106'(mb); // 53 quotient bits.
    if (e <= 0) return '0;
    return {a[63] ^ b[63], e[10:0], q[51:0]};
  endfunction

  function automatic fp_t int_to_double(logic [63:0] n);
    int lz;
    if (n == '0) return '0;
    lz = 0;
    while (!n[63]) begin
      n = n << 1;
      lz = lz + 1;
    end
    return {1'b0, 11'(1023 + 63 - lz), n[62:11]};
  endfunction

  function automatic fp_t series_sum(fp_t x);
    fp_t         sum, prod, term;
    logic [63:0] fact;
    sum = fp_one;
    prod = x;
    term = x;
    fact = 64'd1;
    for (int n = 1; n <= terms; n++) begin
      sum = add_trunc(sum, term);
      if (n < terms) begin
        fact = fact * 64'(n + 1);
        prod = mul_trunc(prod, x);
        term = div_trunc(prod, int_to_double(fact));
      end
    end
    return sum;
  endfunction

  task automatic read_trace();
    int    fd;
    string line;
    fp_t   v;
    fd = $fopen("dv/exp_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/exp_trace.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%h", v) == 1) inputs.push_back(v);
      end
    end
    $fclose(fd);
  endtask

  // waits for done, optionally checking that fp_out holds a value meanwhile.
  task automatic wait_done(input bit check_hold, input fp_t hold, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < done_timeout; i++) begin
      @(posedge clk);
      #1;
      if (done) begin
        seen = 1'b1;
        return;
      end
      if (check_hold) begin
        assert (fp_out === hold) else begin
          $display("Mismatch at %0t: fp_out %h changed before done, held %h",
                   $time, fp_out, hold);
          errors++;
        end
      end
    end
    $display("timeout waiting for done");
    timeouts++;
  endtask

  task automatic pulse_start(input fp_t x);
    @(posedge clk);
    #5;
    fp_in = x;
    start = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
  endtask

  task automatic check_result(input fp_t x);
    fp_t exp_v;
    exp_v = series_sum(x);
    assert (fp_out === exp_v) else begin
      $display("Mismatch at %0t: in %h expected %h got %h", $time, x, exp_v, fp_out);
      errors++;
    end
  endtask

  task automatic run_job(input fp_t x, input bit check_hold, input fp_t hold);
    bit seen;
    pulse_start(x);
    wait_done(check_hold, hold, seen);
    if (seen) check_result(x);
  endtask

  task automatic run_with_extra_start(input fp_t x, input fp_t other);
    bit seen;
    pulse_start(x);
    repeat (2) @(posedge clk); // second pulse 3 cycles after the first.
    #5;
    fp_in = other;
    start = 1'b1;
    @(posedge clk);
    #5;
    start = 1'b0;
    wait_done(1'b0, '0, seen);
    if (seen) begin
      check_result(x);
      // long enough for a whole second job to finish.
      for (int i = 0; i < done_timeout; i++) begin
        @(posedge clk);
        #1;
        assert (!done) else begin
          $display("second done pulse after a start while busy");
          errors++;
        end
      end
    end
  endtask

  initial begin
    fp_t prev;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    fp_in = '0;
    errors = 0;
    timeouts = 0;
    read_trace();
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      if (i == 7) #5 rst_n = 1'b1;
      else #1;
      assert (done === 1'b0 && fp_out === '0) else begin
        $display("Mismatch at %0t: idle output done %b fp_out %h", $time, done, fp_out);
        errors++;
      end
    end
    foreach (inputs[i]) begin
      run_job(inputs[i], 1'b0, '0);
      if (inputs[i] == '0) begin
        assert (fp_out === fp_one) else begin
          $display("Mismatch at %0t: exp(0) gave %h", $time, fp_out);
          errors++;
        end
      end
    end
    if (inputs.size() > 3) run_with_extra_start(inputs[1], inputs[3]);
    prev = fp_out;
    for (int i = inputs.size() - 1; i >= 0; i--) begin
      run_job(inputs[i], 1'b1, prev);
      prev = fp_out;
    end
    $display("errors: %0d timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0 && inputs.size() > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
verilog/fp_exp_pkg.sv
verilog/fp_op_if.sv
verilog/term_counter.sv
verilog/fp_adder.sv
verilog/fp_mult.sv
verilog/fp_divider.sv
verilog/long_to_fp.sv
verilog/exp_sequencer.sv
verilog/fp_exp_top.sv
dv/fp_exp_sva.sv
dv/fp_exp_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module fp_exp_tb -o fp_exp_sim
out=$(./obj_dir/fp_exp_sim)
echo "$out"
grep -q "STATUS: PASS" <<< "$out"

// File: verilog/exp_sequencer.sv
module exp_sequencer import fp_exp_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  fp_t  fp_in,
  input  logic start,
  input  logic last,
  output logic clear,
  output logic advance,
  output fp_t  fp_out,
  output logic done,
  fp_op_if.client add_if,
  fp_op_if.client mul_if,
  fp_op_if.client div_if,
  fp_op_if.client conv_if
);

  seq_state_t state;

  fp_t x;
  fp_t sum;
  fp_t prod;  // x^n.
  fp_t term;  // x^n / n!.
  fp_t result;

  assign clear   = (state == idle) && start;
  assign advance = (state == wait_add) && add_if.done && !last;
  assign done    = (state == finish);
  assign fp_out  = result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= idle;
      add_if.start  <= 1'b0;
      mul_if.start  <= 1'b0;
      div_if.start  <= 1'b0;
      conv_if.start <= 1'b0;
      result        <= '0;
    end else begin
      add_if.start  <= 1'b0;
      mul_if.start  <= 1'b0;
      div_if.start  <= 1'b0;
      conv_if.start <= 1'b0;
      case (state)
        idle:      if (start) state <= add_term;
        add_term: begin
          add_if.start <= 1'b1;
          state        <= wait_add;
        end
        wait_add: begin
          if (add_if.done) begin
            if (last) begin
              result <= add_if.c; // shown from the done cycle on.
              state  <= finish;
            end else begin
              state <= mul_x;
            end
          end
        end
        mul_x: begin
          mul_if.start <= 1'b1;
          state        <= wait_mul;
        end
        wait_mul:  if (mul_if.done) state <= conv_fact;
        conv_fact: begin
          conv_if.start <= 1'b1;
          state         <= wait_conv;
        end
        wait_conv: if (conv_if.done) state <= div_fact;
        div_fact: begin
          div_if.start <= 1'b1;
          state        <= wait_div;
        end
        wait_div:  if (div_if.done) state <= add_term;
        finish:    state <= idle;
        default:   state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) begin
          x    <= fp_in;
          sum  <= fp_one;
          prod <= fp_in;
          term <= fp_in;
        end
      end
      add_term: begin
        add_if.a <= sum;
        add_if.b <= term;
      end
      wait_add: if (add_if.done) sum <= add_if.c;
      mul_x: begin
        mul_if.a <= prod;
        mul_if.b <= x;
      end
      wait_mul: if (mul_if.done) prod <= mul_if.c;
      div_fact: begin
        div_if.a <= prod;
        div_if.b <= conv_if.c; // converter output holds after done.
      end
      wait_div: if (div_if.done) term <= div_if.c;
      default: ;
    endcase
  end

endmodule

// File: verilog/fp_adder.sv
module fp_adder import fp_exp_pkg::*; (
  input logic clk,
  input logic rst_n,
  fp_op_if.unit op
);

  logic [exp_width-1:0]  exp_a;
  logic [exp_width-1:0]  exp_b;
  logic [man_width:0]    man_a;
  logic [man_width:0]    man_b;
  logic                  a_big;
  logic [exp_width-1:0]  exp_diff;
  logic [man_width:0]    man_large;
  logic [man_width:0]    man_small;
  logic [man_width+1:0]  man_sum;

  logic                  s1_valid;
  logic                  s1_sign;
  logic [exp_width-1:0]  s1_exp;
  logic [man_width+1:0]  s1_man;

  logic [6:0]                  lz;
  logic signed [exp_width+1:0] norm_exp;
  logic [man_width:0]          norm_man;

  assign exp_a = op.a[man_width +: exp_width];
  assign exp_b = op.b[man_width +: exp_width];
  assign man_a = (exp_a == '0) ? '0 : {1'b1, op.a[man_width-1:0]};
  assign man_b = (exp_b == '0) ? '0 : {1'b1, op.b[man_width-1:0]};

  // magnitude compare on exponent and fraction together.
  assign a_big = op.a[man_width+exp_width-1:0] >= op.b[man_width+exp_width-1:0];
  assign exp_diff  = a_big ? exp_a - exp_b : exp_b - exp_a;
  assign man_large = a_big ? man_a : man_b;
  assign man_small = (a_big ? man_b : man_a) >> exp_diff; // shifted-out bits lost.

  always_comb begin
    if (op.a[63] == op.b[63]) begin
      man_sum = {1'b0, man_large} + {1'b0, man_small};
    end else begin
      man_sum = {1'b0, man_large} - {1'b0, man_small};
    end
  end

  // low padding of ones caps the count at 53.
  assign lz = lead_zeros({s1_man[man_width:0], {exp_width{1'b1}}});

  always_comb begin
    if (s1_man[man_width+1]) begin
      norm_man = s1_man[man_width+1:1]; // carry out, shift right once.
      norm_exp = $signed({2'b00, s1_exp}) + 13'sd1;
    end else begin
      norm_man = s1_man[man_width:0] << lz;
      norm_exp = $signed({2'b00, s1_exp}) - $signed({6'd0, lz});
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      op.done  <= 1'b0;
    end else begin
      s1_valid <= op.start;
      op.done  <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op.start) begin
      s1_sign <= a_big ? op.a[63] : op.b[63];
      s1_exp  <= a_big ? exp_a : exp_b;
      s1_man  <= man_sum;
    end
    if (s1_valid) begin
      if (s1_man == '0 || norm_exp <= 0) begin
        op.c <= '0; // cancellation and underflow both give +0.
      end else begin
        op.c <= {s1_sign, norm_exp[exp_width-1:0], norm_man[man_width-1:0]};
      end
    end
  end

endmodule

// File: verilog/fp_divider.sv
module fp_divider import fp_exp_pkg::*; (
  input logic clk,
  input logic rst_n,
  fp_op_if.unit op
);

  logic [exp_width-1:0]        exp_a;
  logic [exp_width-1:0]        exp_b;
  logic [man_width:0]          man_a;
  logic [man_width:0]          man_b;

  logic                        busy;
  logic                        pre_norm; // dividend below divisor, shift once first.
  logic [5:0]                  cnt;
  logic                        last_bit;

  logic [man_width+1:0]        rem;
  logic [man_width:0]          divisor;
  logic [man_width-1:0]        quo;
  logic                        q_bit;
  logic [man_width+1:0]        rem_sub;
  logic                        sign_q;
  logic                        zero_q;
  logic signed [exp_width+1:0] exp_q;

  assign exp_a = op.a[man_width +: exp_width];
  assign exp_b = op.b[man_width +: exp_width];
  assign man_a = (exp_a == '0) ? '0 : {1'b1, op.a[man_width-1:0]};
  assign man_b = {1'b1, op.b[man_width-1:0]};

  assign q_bit    = rem >= {1'b0, divisor};
  assign rem_sub  = q_bit ? rem - {1'b0, divisor} : rem;
  assign last_bit = busy && !pre_norm && (cnt == 6'(man_width));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      pre_norm <= 1'b0;
      cnt      <= '0;
      op.done  <= 1'b0;
    end else begin
      op.done <= 1'b0;
      if (op.start) begin
        busy     <= 1'b1;
        pre_norm <= man_a < man_b;
        cnt      <= '0;
      end else if (busy) begin
        if (pre_norm) begin
          pre_norm <= 1'b0;
        end else if (last_bit) begin
          busy    <= 1'b0;
          op.done <= 1'b1;
        end else begin
          cnt <= cnt + 6'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (op.start) begin
      rem     <= {1'b0, man_a};
      divisor <= man_b;
      sign_q  <= op.a[63] ^ op.b[63];
      zero_q  <= (exp_a == '0);
      exp_q   <= {2'b00, exp_a} - {2'b00, exp_b} + (exp_width+2)'(exp_bias);
    end else if (busy && pre_norm) begin
      rem   <= rem << 1;
      exp_q <= exp_q - 13'sd1;
    end else if (busy) begin
      rem <= rem_sub << 1;
      quo <= {quo[man_width-2:0], q_bit};
      if (last_bit) begin
        // 53 quotient bits, leading one dropped, rest truncated.
        if (zero_q || exp_q <= 0) op.c <= '0;
        else op.c <= {sign_q, exp_q[exp_width-1:0], quo[man_width-2:0], q_bit};
      end
    end
  end

endmodule

// File: verilog/fp_exp_pkg.sv
package fp_exp_pkg;

  localparam int exp_width = 11;
  localparam int man_width = 52;
  localparam int exp_bias = 1023;

  typedef logic [63:0] fp_t;

  localparam fp_t fp_one = 64'h3ff0000000000000;

  typedef enum logic [3:0] {
    idle,
    add_term,
    wait_add,
    mul_x,
    wait_mul,
    conv_fact,
    wait_conv,
    div_fact,
    wait_div,
    finish
  } seq_state_t;

  // number of zeros above the leading one, 64 for a zero word.
  function automatic logic [6:0] lead_zeros(input logic [63:0] v);
    logic [6:0] n;
    logic found;
    n = '0;
    found = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 7'd1;
      end
    end
    return n;
  endfunction

endpackage

// File: verilog/fp_exp_top.sv
module fp_exp_top import fp_exp_pkg::*; #(
  parameter int iterations = 7
) (
  input  logic clk,
  input  logic rst_n,
  input  fp_t  fp_in,
  input  logic start,
  output fp_t  fp_out,
  output logic done
);

  logic        clear;
  logic        advance;
  logic        last;
  logic [63:0] factorial;

  fp_op_if add_if ();
  fp_op_if mul_if ();
  fp_op_if div_if ();
  fp_op_if conv_if ();

  assign conv_if.a = factorial;
  assign conv_if.b = '0; // converter reads a only.

  exp_sequencer seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .fp_in   (fp_in),
    .start   (start),
    .last    (last),
    .clear   (clear),
    .advance (advance),
    .fp_out  (fp_out),
    .done    (done),
    .add_if  (add_if.client),
    .mul_if  (mul_if.client),
    .div_if  (div_if.client),
    .conv_if (conv_if.client)
  );

  term_counter #(
    .iterations (iterations)
  ) counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .advance   (advance),
    .factorial (factorial),
    .last      (last)
  );

  fp_adder   adder   (.clk(clk), .rst_n(rst_n), .op(add_if.unit));
  fp_mult    mult    (.clk(clk), .rst_n(rst_n), .op(mul_if.unit));
  fp_divider divider (.clk(clk), .rst_n(rst_n), .op(div_if.unit));
  long_to_fp conv    (.clk(clk), .rst_n(rst_n), .op(conv_if.unit));

endmodule

// File: verilog/fp_mult.sv
module fp_mult import fp_exp_pkg::*; (
  input logic clk,
  input logic rst_n,
  fp_op_if.unit op
);

  logic [exp_width-1:0]        exp_a;
  logic [exp_width-1:0]        exp_b;

  logic                        s1_valid;
  logic                        s1_sign;
  logic                        s1_zero;
  logic signed [exp_width+1:0] s1_exp;
  logic [2*man_width+1:0]      s1_prod;

  logic signed [exp_width+1:0] norm_exp;
  logic [man_width-1:0]        norm_frac;

  assign exp_a = op.a[man_width +: exp_width];
  assign exp_b = op.b[man_width +: exp_width];

  // product of two 1.f values lies in [1, 4).
  always_comb begin
    if (s1_prod[2*man_width+1]) begin
      norm_frac = s1_prod[2*man_width -: man_width];
      norm_exp  = s1_exp + 13'sd1;
    end else begin
      norm_frac = s1_prod[2*man_width-1 -: man_width];
      norm_exp  = s1_exp;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      op.done  <= 1'b0;
    end else begin
      s1_valid <= op.start;
      op.done  <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op.start) begin
      s1_sign <= op.a[63] ^ op.b[63];
      s1_zero <= (exp_a == '0) || (exp_b == '0);
      s1_exp  <= {2'b00, exp_a} + {2'b00, exp_b} - (exp_width+2)'(exp_bias);
      s1_prod <= {1'b1, op.a[man_width-1:0]} * {1'b1, op.b[man_width-1:0]};
    end
    if (s1_valid) begin
      if (s1_zero || norm_exp <= 0) op.c <= '0;
      else op.c <= {s1_sign, norm_exp[exp_width-1:0], norm_frac};
    end
  end

endmodule

// File: verilog/fp_op_if.sv
interface fp_op_if import fp_exp_pkg::*; ();

  fp_t  a;
  fp_t  b;
  logic start;
  fp_t  c;
  logic done;

  modport client (
    output a,
    output b,
    output start,
    input  c,
    input  done
  );

  modport unit (
    input  a,
    input  b,
    input  start,
    output c,
    output done
  );

endinterface

// File: verilog/long_to_fp.sv
module long_to_fp import fp_exp_pkg::*; (
  input logic clk,
  input logic rst_n,
  fp_op_if.unit op
);

  logic [6:0]           lz;
  logic [63:0]          shifted;
  logic [exp_width-1:0] exp_c;

  assign lz      = lead_zeros(op.a);
  assign shifted = op.a << lz; // leading one lands on bit 63.
  assign exp_c   = exp_width'(exp_bias + 63 - int'(lz));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.done <= 1'b0;
    end else begin
      op.done <= op.start;
    end
  end

  always_ff @(posedge clk) begin
    if (op.start) begin
      if (op.a == '0) begin
        op.c <= '0;
      end else begin
        op.c <= {1'b0, exp_c, shifted[62 -: man_width]}; // low bits truncated.
      end
    end
  end

endmodule

// File: verilog/term_counter.sv
module term_counter #(
  parameter int iterations = 7
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear,
  input  logic        advance,
  output logic [63:0] factorial,
  output logic        last
);

  logic [5:0] index;
  logic [5:0] index_next;

  assign index_next = index + 6'd1;
  assign last = (index == 6'(iterations));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index     <= 6'd1;
      factorial <= 64'd1;
    end else if (clear) begin
      index     <= 6'd1;
      factorial <= 64'd1;
    end else if (advance) begin
      index     <= index_next;
      factorial <= factorial * {58'd0, index_next}; // n! = (n-1)! * n.
    end
  end

endmodule
